// ==== rtl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	typedef logic [31:0] word_t;     // Data word
	typedef logic [31:0] addr_t;     // Byte address
	typedef logic [5:0]  ctrl_t;     // Memory control word
	typedef logic [2:0]  size_t;     // One-hot access size
	typedef logic [3:0]  byte_en_t;  // One enable per byte lane

	////////////////////////////////////////////////////////////
	// Control word layout
	////////////////////////////////////////////////////////////

	// Bit 5 set means the load result is zero-extended
	localparam int CTRL_UNSIGNED = 5;
	localparam int CTRL_READ     = 4;
	localparam int CTRL_WRITE    = 3;
	localparam int CTRL_SIZE_LSB = 0;

	////////////////////////////////////////////////////////////
	// Size codes
	////////////////////////////////////////////////////////////

	localparam size_t SIZE_BYTE = 3'b001;
	localparam size_t SIZE_HALF = 3'b010;
	localparam size_t SIZE_WORD = 3'b100;

endpackage

`default_nettype wire

// ==== rtl/store_align.sv ====
`default_nettype none

module store_align
(
	input  wire mem_pkg::size_t    size_i,
	input  wire logic [1:0]        addr_lo_i,
	input  wire mem_pkg::word_t    wdata_i,
	input  wire logic              write_en_i,
	output mem_pkg::word_t         wdata_o,
	output mem_pkg::byte_en_t      be_o
);

	mem_pkg::byte_en_t lane_be;

	// Data is copied onto every lane it can occupy, so only the enables
	// depend on the address
	always_comb
	begin
		case (size_i)
			mem_pkg::SIZE_BYTE:
			begin
				wdata_o = {4{wdata_i[7:0]}};
				lane_be = 4'b0001 << addr_lo_i;
			end

			mem_pkg::SIZE_HALF:
			begin
				wdata_o = {2{wdata_i[15:0]}};
				if (addr_lo_i[1])
				begin
					lane_be = 4'b1100;  // Upper half word
				end
				else
				begin
					lane_be = 4'b0011;
				end
			end

			mem_pkg::SIZE_WORD:
			begin
				wdata_o = wdata_i;
				lane_be = 4'b1111;
			end

			default:
			begin
				wdata_o = '0;
				lane_be = 4'b0000;  // Not one-hot, nothing is written
			end
		endcase
	end

	assign be_o = write_en_i ? lane_be : 4'b0000;

endmodule

`default_nettype wire

// ==== rtl/load_extend.sv ====
`default_nettype none

module load_extend
(
	input  wire                    clock_i,
	input  wire                    reset_i,
	input  wire logic              load_i,
	input  wire mem_pkg::size_t    size_i,
	input  wire logic [1:0]        addr_lo_i,
	input  wire logic              unsigned_i,
	input  wire mem_pkg::word_t    rdata_i,
	output logic                   load_valid_o,
	output mem_pkg::word_t         load_data_o
);

	logic           load_q;
	mem_pkg::size_t size_q;
	logic [1:0]     lane_q;
	logic           unsigned_q;

	logic [7:0]     lane_byte;
	logic [15:0]    lane_half;
	mem_pkg::word_t extended;

	////////////////////////////////////////////////////////////
	// Load attributes, held while the RAM word is read
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			load_q <= 1'b0;
		end
		else
		begin
			load_q <= load_i;
		end
	end

	always_ff @(posedge clock_i)
	begin
		size_q     <= size_i;
		lane_q     <= addr_lo_i;
		unsigned_q <= unsigned_i;
	end

	////////////////////////////////////////////////////////////
	// Lane select and extension
	////////////////////////////////////////////////////////////

	assign lane_byte = rdata_i[lane_q*8 +: 8];
	assign lane_half = lane_q[1] ? rdata_i[31:16] : rdata_i[15:0];

	always_comb
	begin
		case (size_q)
			mem_pkg::SIZE_BYTE: extended = {{24{lane_byte[7] & ~unsigned_q}}, lane_byte};
			mem_pkg::SIZE_HALF: extended = {{16{lane_half[15] & ~unsigned_q}}, lane_half};
			mem_pkg::SIZE_WORD: extended = rdata_i;
			default:            extended = '0;
		endcase
	end

	assign load_valid_o = load_q;
	assign load_data_o  = load_q ? extended : '0;  // Quiet bus between loads

	// A result is only ever extracted with a one-hot size
	a_valid_has_size: assert property (
		@(posedge clock_i) disable iff (reset_i)
		load_valid_o |-> $onehot(size_q)
	);

endmodule

`default_nettype wire

// ==== rtl/data_mem.sv ====
`default_nettype none

module data_mem
#(
	parameter int MEM_WORDS = 256
)
(
	input  wire                     clock_i,
	input  wire mem_pkg::addr_t     addr_i,
	input  wire mem_pkg::word_t     wdata_i,
	input  wire mem_pkg::byte_en_t  be_i,
	output mem_pkg::word_t          rdata_o
);

	localparam int INDEX_W = $clog2(MEM_WORDS);

	mem_pkg::word_t     mem [MEM_WORDS];
	logic [INDEX_W-1:0] index;
	mem_pkg::word_t     rdata_q;

	// The depth must be a power of two for the index to wrap cleanly
	if ((MEM_WORDS & (MEM_WORDS - 1)) != 0)
	begin : g_depth_check
		$error("MEM_WORDS must be a power of two");
	end

	assign index = addr_i[INDEX_W+1:2];  // Byte offset bits are not part of the index

	////////////////////////////////////////////////////////////
	// Byte-lane writes
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock_i)
	begin
		for (int lane = 0; lane < 4; lane++)
		begin
			if (be_i[lane])
			begin
				mem[index][lane*8 +: 8] <= wdata_i[lane*8 +: 8];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Registered read
	////////////////////////////////////////////////////////////

	// Old contents are returned when the same word is written in this cycle
	always_ff @(posedge clock_i)
	begin
		rdata_q <= mem[index];
	end

	assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== rtl/mem_fault_regs.sv ====
`default_nettype none

module mem_fault_regs
#(
	parameter int MEM_WORDS = 256
)
(
	input  wire                    clock_i,
	input  wire                    reset_i,
	input  wire logic              req_valid_i,
	input  wire mem_pkg::ctrl_t    req_ctrl_i,
	input  wire mem_pkg::addr_t    req_addr_i,
	input  wire logic              cfg_write_i,
	input  wire logic              cfg_strict_i,
	output logic                   access_ok_o,
	output mem_pkg::addr_t         eff_addr_o,
	output logic                   fault_o,
	output mem_pkg::addr_t         fault_addr_o,
	output logic                   fault_sticky_o,
	output logic                   strict_o
);

	localparam int SPAN_W = $clog2(MEM_WORDS) + 2;  // Byte address bits that reach the RAM

	mem_pkg::size_t size;
	logic           size_ok;
	logic           is_read;
	logic           is_write;
	logic           live;        // A valid read or write with a usable size
	logic           misaligned;
	logic           suppress;
	mem_pkg::addr_t drop_mask;

	logic           strict_q;

	assign size     = req_ctrl_i[mem_pkg::CTRL_SIZE_LSB +: $bits(mem_pkg::size_t)];
	assign is_read  = req_ctrl_i[mem_pkg::CTRL_READ];
	assign is_write = req_ctrl_i[mem_pkg::CTRL_WRITE];

	assign size_ok = (size == mem_pkg::SIZE_BYTE) || (size == mem_pkg::SIZE_HALF) ||
		(size == mem_pkg::SIZE_WORD);

	always_comb
	begin
		case (size)
			mem_pkg::SIZE_HALF: drop_mask = 32'h0000_0001;
			mem_pkg::SIZE_WORD: drop_mask = 32'h0000_0003;
			default:            drop_mask = '0;
		endcase
	end

	assign misaligned = (req_addr_i & drop_mask) != '0;
	assign live       = req_valid_i && (is_read || is_write) && size_ok;
	assign suppress   = live && misaligned && strict_q;

	assign access_ok_o = live && !suppress;

	// Relaxed mode drops the offending low bits, then the address wraps at the RAM size
	assign eff_addr_o = (strict_q ? req_addr_i : (req_addr_i & ~drop_mask)) &
		{{(32 - SPAN_W){1'b0}}, {SPAN_W{1'b1}}};

	////////////////////////////////////////////////////////////
	// Configuration and fault log
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			strict_q       <= 1'b1;
			fault_o        <= 1'b0;
			fault_addr_o   <= '0;
			fault_sticky_o <= 1'b0;
		end
		else
		begin
			fault_o <= suppress;
			if (cfg_write_i)
			begin
				strict_q <= cfg_strict_i;
			end
			if (suppress)
			begin
				fault_addr_o   <= req_addr_i;
				fault_sticky_o <= 1'b1;  // A fault beats a clear in the same cycle
			end
			else if (cfg_write_i)
			begin
				fault_sticky_o <= 1'b0;
			end
		end
	end

	assign strict_o = strict_q;

	a_no_read_write: assert property (
		@(posedge clock_i) disable iff (reset_i)
		req_valid_i |-> !(is_read && is_write)
	);

	a_fault_sets_sticky: assert property (
		@(posedge clock_i) disable iff (reset_i)
		fault_o |-> fault_sticky_o
	);

endmodule

`default_nettype wire

// ==== rtl/mem_stage.sv ====
`default_nettype none

module mem_stage
#(
	parameter int MEM_WORDS = 256
)
(
	input  wire                    clock_i,
	input  wire                    reset_i,
	input  wire logic              req_valid_i,
	input  wire mem_pkg::ctrl_t    req_ctrl_i,
	input  wire mem_pkg::addr_t    req_addr_i,
	input  wire mem_pkg::word_t    req_wdata_i,
	input  wire logic              cfg_write_i,
	input  wire logic              cfg_strict_i,
	output logic                   load_valid_o,
	output mem_pkg::word_t         load_data_o,
	output logic                   fault_o,
	output mem_pkg::addr_t         fault_addr_o,
	output logic                   fault_sticky_o,
	output logic                   strict_o
);

	wire logic              access_ok;
	wire mem_pkg::addr_t    eff_addr;
	wire mem_pkg::word_t    mem_wdata;
	wire mem_pkg::byte_en_t mem_be;
	wire mem_pkg::word_t    mem_rdata;

	wire mem_pkg::size_t    req_size = req_ctrl_i[mem_pkg::CTRL_SIZE_LSB +: $bits(mem_pkg::size_t)];
	wire logic              store_go = access_ok & req_ctrl_i[mem_pkg::CTRL_WRITE];
	wire logic              load_go  = access_ok & req_ctrl_i[mem_pkg::CTRL_READ];

	////////////////////////////////////////////////////////////
	// Request check and address
	////////////////////////////////////////////////////////////

	mem_fault_regs
	#(
		.MEM_WORDS (MEM_WORDS)
	)
	mem_fault_regs_inst
	(
		.clock_i        (clock_i),
		.reset_i        (reset_i),
		.req_valid_i    (req_valid_i),
		.req_ctrl_i     (req_ctrl_i),
		.req_addr_i     (req_addr_i),
		.cfg_write_i    (cfg_write_i),
		.cfg_strict_i   (cfg_strict_i),
		.access_ok_o    (access_ok),
		.eff_addr_o     (eff_addr),
		.fault_o        (fault_o),
		.fault_addr_o   (fault_addr_o),
		.fault_sticky_o (fault_sticky_o),
		.strict_o       (strict_o)
	);

	////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////

	store_align store_align_inst
	(
		.size_i     (req_size),
		.addr_lo_i  (eff_addr[1:0]),
		.wdata_i    (req_wdata_i),
		.write_en_i (store_go),
		.wdata_o    (mem_wdata),
		.be_o       (mem_be)
	);

	data_mem
	#(
		.MEM_WORDS (MEM_WORDS)
	)
	data_mem_inst
	(
		.clock_i (clock_i),
		.addr_i  (eff_addr),
		.wdata_i (mem_wdata),
		.be_i    (mem_be),
		.rdata_o (mem_rdata)
	);

	// Lane and sign mode travel alongside the RAM read
	load_extend load_extend_inst
	(
		.clock_i      (clock_i),
		.reset_i      (reset_i),
		.load_i       (load_go),
		.size_i       (req_size),
		.addr_lo_i    (eff_addr[1:0]),
		.unsigned_i   (req_ctrl_i[mem_pkg::CTRL_UNSIGNED]),
		.rdata_i      (mem_rdata),
		.load_valid_o (load_valid_o),
		.load_data_o  (load_data_o)
	);

endmodule

`default_nettype wire

// ==== bench/mem_stage_tb.sv ====
`default_nettype none

module mem_stage_tb;

	localparam int MEM_WORDS      = 256;
	localparam int INDEX_W        = $clog2(MEM_WORDS);
	localparam int TEST_CYCLES    = 400;               // Rough length of all tests together
	localparam int TIMEOUT_CYCLES = 5 * TEST_CYCLES;

	logic           clock_i;
	logic           reset_i;
	logic           req_valid_i;
	mem_pkg::ctrl_t req_ctrl_i;
	mem_pkg::addr_t req_addr_i;
	mem_pkg::word_t req_wdata_i;
	logic           cfg_write_i;
	logic           cfg_strict_i;
	logic           load_valid_o;
	mem_pkg::word_t load_data_o;
	logic           fault_o;
	mem_pkg::addr_t fault_addr_o;
	logic           fault_sticky_o;
	logic           strict_o;

	// Reference model state, and what the DUT must show after the next edge
	mem_pkg::word_t model_mem [MEM_WORDS];
	logic           model_strict;
	logic           exp_valid;
	mem_pkg::word_t exp_data;
	logic           exp_fault;
	mem_pkg::addr_t exp_fault_addr;
	logic           exp_sticky;

	integer seed = 32'ha30b;
	int     cycle_count = 0;

	mem_stage
	#(
		.MEM_WORDS (MEM_WORDS)
	)
	mem_stage_inst
	(
		.clock_i        (clock_i),
		.reset_i        (reset_i),
		.req_valid_i    (req_valid_i),
		.req_ctrl_i     (req_ctrl_i),
		.req_addr_i     (req_addr_i),
		.req_wdata_i    (req_wdata_i),
		.cfg_write_i    (cfg_write_i),
		.cfg_strict_i   (cfg_strict_i),
		.load_valid_o   (load_valid_o),
		.load_data_o    (load_data_o),
		.fault_o        (fault_o),
		.fault_addr_o   (fault_addr_o),
		.fault_sticky_o (fault_sticky_o),
		.strict_o       (strict_o)
	);

	initial
	begin
		clock_i = 1'b0;
		forever
		begin
			#2 clock_i = ~clock_i;
		end
	end

	always @(posedge clock_i)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$fatal(1, "Simulation timeout");
		end
	end

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "Check failed");
	endtask

	task automatic check_word(input string name, input mem_pkg::word_t expected,
		input mem_pkg::word_t actual);
		if (actual !== expected)
			abort_run($sformatf("** Error at %0t: %s expected %h, got %h",
				$time, name, expected, actual));
	endtask

	task automatic check_addr(input string name, input mem_pkg::addr_t expected,
		input mem_pkg::addr_t actual);
		if (actual !== expected)
			abort_run($sformatf("** Error at %0t: %s expected %h, got %h",
				$time, name, expected, actual));
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			abort_run($sformatf("** Error at %0t: %s expected %b, got %b",
				$time, name, expected, actual));
	endtask

	task automatic check_outputs();
		if (load_valid_o !== exp_valid)
		begin
			if (exp_valid)
				abort_run("load result expected but none arrived");
			else
				abort_run("load result arrived with no load pending");
		end
		check_word("load_data_o", exp_data, load_data_o);
		check_bit("fault_o", exp_fault, fault_o);
		check_addr("fault_addr_o", exp_fault_addr, fault_addr_o);
		check_bit("fault_sticky_o", exp_sticky, fault_sticky_o);
		check_bit("strict_o", model_strict, strict_o);
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic mem_pkg::ctrl_t make_ctrl(input logic rd, input logic wr,
		input logic uns, input mem_pkg::size_t size);
		mem_pkg::ctrl_t ctrl;
		ctrl = '0;
		ctrl[mem_pkg::CTRL_SIZE_LSB +: 3] = size;
		ctrl[mem_pkg::CTRL_READ]          = rd;
		ctrl[mem_pkg::CTRL_WRITE]         = wr;
		ctrl[mem_pkg::CTRL_UNSIGNED]      = uns;
		return ctrl;
	endfunction

	function automatic mem_pkg::word_t extend_lane(input mem_pkg::word_t value,
		input mem_pkg::size_t size, input logic [1:0] lo, input logic uns);
		mem_pkg::word_t shifted;
		mem_pkg::word_t result;
		shifted = value >> (lo * 8);
		result  = '0;
		if (size == mem_pkg::SIZE_BYTE)
			result = uns ? {24'h0, shifted[7:0]} : {{24{shifted[7]}}, shifted[7:0]};
		else if (size == mem_pkg::SIZE_HALF)
			result = uns ? {16'h0, shifted[15:0]} : {{16{shifted[15]}}, shifted[15:0]};
		else if (size == mem_pkg::SIZE_WORD)
			result = value;
		return result;
	endfunction

	task automatic predict(input logic valid, input mem_pkg::ctrl_t ctrl,
		input mem_pkg::addr_t addr, input mem_pkg::word_t wdata, input logic cfg_w,
		input logic cfg_s);
		mem_pkg::size_t     size;
		logic               rd;
		logic               wr;
		logic               size_ok;
		logic [1:0]         low_mask;
		logic               accepted;
		logic               blocked;
		mem_pkg::addr_t     eff;
		logic [INDEX_W-1:0] idx;
		mem_pkg::word_t     cur_word;

		size    = ctrl[mem_pkg::CTRL_SIZE_LSB +: 3];
		rd      = ctrl[mem_pkg::CTRL_READ];
		wr      = ctrl[mem_pkg::CTRL_WRITE];
		size_ok = size == mem_pkg::SIZE_BYTE || size == mem_pkg::SIZE_HALF ||
			size == mem_pkg::SIZE_WORD;
		low_mask = 2'b00;
		if (size == mem_pkg::SIZE_HALF)
			low_mask = 2'b01;
		if (size == mem_pkg::SIZE_WORD)
			low_mask = 2'b11;

		accepted = valid && (rd || wr) && size_ok;
		blocked  = accepted && model_strict && ((addr[1:0] & low_mask) != 2'b00);
		eff      = addr;
		if (!model_strict)
			eff[1:0] = addr[1:0] & ~low_mask;  // Relaxed mode drops the offending bits
		idx      = eff[INDEX_W+1:2];
		cur_word = model_mem[idx];

		exp_valid = 1'b0;
		exp_data  = '0;
		exp_fault = blocked;
		if (accepted && !blocked && wr)
		begin
			if (size == mem_pkg::SIZE_BYTE)
				cur_word[eff[1:0]*8 +: 8] = wdata[7:0];
			else if (size == mem_pkg::SIZE_HALF)
				cur_word[eff[1]*16 +: 16] = wdata[15:0];
			else
				cur_word = wdata;
			model_mem[idx] = cur_word;
		end
		if (accepted && !blocked && rd)
		begin
			exp_valid = 1'b1;
			exp_data  = extend_lane(cur_word, size, eff[1:0], ctrl[mem_pkg::CTRL_UNSIGNED]);
		end
		if (blocked)
		begin
			exp_fault_addr = addr;
			exp_sticky     = 1'b1;
		end
		else if (cfg_w)
		begin
			exp_sticky = 1'b0;
		end
		if (cfg_w)
			model_strict = cfg_s;  // Takes effect for the next request
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// Checks the previous cycle's results, then drives the next cycle's inputs
	task automatic step(input logic valid, input mem_pkg::ctrl_t ctrl,
		input mem_pkg::addr_t addr, input mem_pkg::word_t wdata, input logic cfg_w,
		input logic cfg_s);
		@(posedge clock_i);
		#1;
		check_outputs();
		req_valid_i  = valid;
		req_ctrl_i   = ctrl;
		req_addr_i   = addr;
		req_wdata_i  = wdata;
		cfg_write_i  = cfg_w;
		cfg_strict_i = cfg_s;
		predict(valid, ctrl, addr, wdata, cfg_w, cfg_s);
	endtask

	task automatic idle();
		step(1'b0, '0, '0, '0, 1'b0, 1'b0);
	endtask

	task automatic configure(input logic strict);
		step(1'b0, '0, '0, '0, 1'b1, strict);
	endtask

	task automatic issue_store(input mem_pkg::size_t size, input mem_pkg::addr_t addr,
		input mem_pkg::word_t data);
		step(1'b1, make_ctrl(1'b0, 1'b1, 1'b0, size), addr, data, 1'b0, 1'b0);
	endtask

	task automatic issue_load(input mem_pkg::size_t size, input logic uns,
		input mem_pkg::addr_t addr);
		step(1'b1, make_ctrl(1'b1, 1'b0, uns, size), addr, '0, 1'b0, 1'b0);
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic test_word_traffic();
		mem_pkg::addr_t addrs [32];
		for (int i = 0; i < 32; i++)
		begin
			addrs[i] = $random(seed) & 32'h0000_03fc;
			issue_store(mem_pkg::SIZE_WORD, addrs[i], $random(seed));
		end
		for (int i = 0; i < 32; i++)
			issue_load(mem_pkg::SIZE_WORD, 1'b0, addrs[i]);
		idle();
	endtask

	task automatic test_byte_half();
		mem_pkg::addr_t base;
		mem_pkg::word_t data;
		for (int w = 0; w < 4; w++)
		begin
			base = 32'h0000_0100 + w * 4;
			issue_store(mem_pkg::SIZE_WORD, base, $random(seed));
			for (int lane = 0; lane < 4; lane++)
			begin
				data    = $random(seed);
				data[7] = lane[0] ^ w[0];  // Half of the bytes are negative
				issue_store(mem_pkg::SIZE_BYTE, base + lane, data);
			end
			issue_load(mem_pkg::SIZE_WORD, 1'b0, base);
			for (int lane = 0; lane < 4; lane++)
			begin
				issue_load(mem_pkg::SIZE_BYTE, 1'b0, base + lane);
				issue_load(mem_pkg::SIZE_BYTE, 1'b1, base + lane);
			end
			for (int half = 0; half < 2; half++)
			begin
				data     = $random(seed);
				data[15] = half[0] ^ w[1];
				issue_store(mem_pkg::SIZE_HALF, base + half * 2, data);
			end
			issue_load(mem_pkg::SIZE_WORD, 1'b0, base);
			for (int half = 0; half < 2; half++)
			begin
				issue_load(mem_pkg::SIZE_HALF, 1'b0, base + half * 2);
				issue_load(mem_pkg::SIZE_HALF, 1'b1, base + half * 2);
			end
		end
		idle();
	endtask

	task automatic test_load_after_store();
		issue_store(mem_pkg::SIZE_WORD, 32'h0000_0180, $random(seed));
		issue_load(mem_pkg::SIZE_WORD, 1'b0, 32'h0000_0180);
		issue_store(mem_pkg::SIZE_BYTE, 32'h0000_0182, $random(seed));
		issue_load(mem_pkg::SIZE_WORD, 1'b0, 32'h0000_0180);
		issue_store(mem_pkg::SIZE_HALF, 32'h0000_0180, 32'h0000_8001);
		issue_load(mem_pkg::SIZE_HALF, 1'b0, 32'h0000_0180);
		idle();
	endtask

	task automatic test_strict_faults();
		mem_pkg::word_t data;
		data = $random(seed);
		configure(1'b1);
		issue_store(mem_pkg::SIZE_WORD, 32'h0000_0040, data);
		issue_store(mem_pkg::SIZE_HALF, 32'h0000_0041, ~data);
		issue_load(mem_pkg::SIZE_WORD, 1'b0, 32'h0000_0040);
		issue_load(mem_pkg::SIZE_WORD, 1'b0, 32'h0000_0042);
		idle();
		idle();      // Sticky flag must hold
		configure(1'b1);
		idle();
		// Fault and clear in one cycle, the fault wins
		step(1'b1, make_ctrl(1'b0, 1'b1, 1'b0, mem_pkg::SIZE_WORD), 32'h0000_0043, ~data,
			1'b1, 1'b1);
		idle();
		issue_load(mem_pkg::SIZE_WORD, 1'b0, 32'h0000_0040);
		configure(1'b1);
		idle();
	endtask

	task automatic test_relaxed();
		configure(1'b0);
		issue_store(mem_pkg::SIZE_WORD, 32'h0000_0083, $random(seed));  // Lands at 0x80
		issue_load(mem_pkg::SIZE_WORD, 1'b0, 32'h0000_0080);
		issue_load(mem_pkg::SIZE_WORD, 1'b1, 32'h0000_0081);
		issue_store(mem_pkg::SIZE_WORD, 32'h0000_0084, $random(seed));
		issue_store(mem_pkg::SIZE_HALF, 32'h0000_0087, 32'h0000_f00d);
		issue_load(mem_pkg::SIZE_HALF, 1'b0, 32'h0000_0087);
		issue_load(mem_pkg::SIZE_HALF, 1'b1, 32'h0000_0085);
		issue_load(mem_pkg::SIZE_WORD, 1'b0, 32'h0000_0086);
		configure(1'b1);
		idle();
	endtask

	task automatic test_invalid_ops();
		mem_pkg::word_t data;
		data = $random(seed);
		issue_store(mem_pkg::SIZE_WORD, 32'h0000_0200, data);
		step(1'b1, make_ctrl(1'b0, 1'b1, 1'b0, 3'b011), 32'h0000_0200, ~data, 1'b0, 1'b0);
		step(1'b1, make_ctrl(1'b0, 1'b1, 1'b0, 3'b000), 32'h0000_0201, ~data, 1'b0, 1'b0);
		step(1'b1, make_ctrl(1'b1, 1'b0, 1'b0, 3'b110), 32'h0000_0200, '0, 1'b0, 1'b0);
		// Neither read nor write, at a misaligned address
		step(1'b1, make_ctrl(1'b0, 1'b0, 1'b0, mem_pkg::SIZE_WORD), 32'h0000_0201, ~data,
			1'b0, 1'b0);
		issue_load(mem_pkg::SIZE_WORD, 1'b0, 32'h0000_0200);
		idle();
	endtask

	initial
	begin
		reset_i        = 1'b1;
		req_valid_i    = 1'b0;
		req_ctrl_i     = '0;
		req_addr_i     = '0;
		req_wdata_i    = '0;
		cfg_write_i    = 1'b0;
		cfg_strict_i   = 1'b0;
		model_strict   = 1'b1;   // Strict mode after reset
		exp_valid      = 1'b0;
		exp_data       = '0;
		exp_fault      = 1'b0;
		exp_fault_addr = '0;
		exp_sticky     = 1'b0;

		repeat (5) @(posedge clock_i);
		#1;
		reset_i = 1'b0;

		test_word_traffic();
		test_byte_half();
		test_load_after_store();
		test_strict_faults();
		test_relaxed();
		test_invalid_ops();

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/mem_pkg.sv
rtl/store_align.sv
rtl/load_extend.sv
rtl/data_mem.sv
rtl/mem_fault_regs.sv
rtl/mem_stage.sv
bench/mem_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module mem_stage_tb \
	-f tb.f -o mem_stage_sim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/mem_stage_sim > sim.log 2>&1
cat sim.log

grep -q "^TEST PASSED$" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
